// ==== Makefile ====
TOP = sound_classifier_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f sound_classifier.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sound_classifier.f

clean:
	rm -rf obj_dir sim.log

// ==== sound_classifier.f ====
+incdir+include
verilog/sound_classifier_pkg.sv
verilog/band_decode.sv
verilog/band_peak.sv
verilog/activity_tracker.sv
verilog/sound_classifier.sv
test/sound_classifier_tb.sv

// ==== include/classifier_model.svh ====
`ifndef CLASSIFIER_MODEL_SVH
`define CLASSIFIER_MODEL_SVH

// model copy of the tracker state
sound_classifier_pkg::activity_state_t model_state;
sound_classifier_pkg::frame_count_t    model_on_count;
sound_classifier_pkg::frame_count_t    model_off_count;
sound_classifier_pkg::frame_count_t    model_hold_count;

bit model_expected[$];  // one entry per frame, oldest first

function automatic sound_classifier_pkg::mag_t model_band_peak(
  sound_classifier_pkg::frame_t frame, int low, int high);
  sound_classifier_pkg::mag_t peak;
  sound_classifier_pkg::mag_t bin_mag;

  peak = '0;
  for (int i = low; i <= high; i++) begin
    bin_mag = frame[i*sound_classifier_pkg::MAG_W +: sound_classifier_pkg::MAG_W];
    if (bin_mag > peak) begin
      peak = bin_mag;
    end
  end
  return peak;
endfunction

function automatic bit model_detect(sound_classifier_pkg::frame_t frame, int low, int high,
                                    sound_classifier_pkg::mag_t thr);
  return model_band_peak(frame, low, high) > thr;
endfunction

function void model_reset();
  model_state      = sound_classifier_pkg::SILENT;
  model_on_count   = '0;
  model_off_count  = '0;
  model_hold_count = '0;
  model_expected.delete();
endfunction

function void model_update(bit det);
  bit on_hit;
  bit off_hit;
  bit curr;

  if (det) begin
    model_off_count = '0;
    if (model_on_count != sound_classifier_pkg::ON_FRAMES) model_on_count++;
  end else begin
    model_on_count = '0;
    if (model_off_count != sound_classifier_pkg::OFF_FRAMES) model_off_count++;
  end
  on_hit  = (model_on_count == sound_classifier_pkg::ON_FRAMES);
  off_hit = (model_off_count == sound_classifier_pkg::OFF_FRAMES);
  curr = ((model_state == sound_classifier_pkg::SOUNDING) || on_hit) && !off_hit;
  model_expected.push_back(curr || (model_hold_count != '0));
  if (on_hit) model_state = sound_classifier_pkg::SOUNDING;
  else if (off_hit) model_state = sound_classifier_pkg::SILENT;
  if (curr) model_hold_count = sound_classifier_pkg::HOLD_FRAMES;
  else if (model_hold_count != '0) model_hold_count--;
endfunction

`endif

// ==== test/sound_classifier_tb.sv ====
`timescale 1ns/1ns

module sound_classifier_tb;

  logic                           clk;
  logic                           reset;
  logic                           recv_val;
  sound_classifier_pkg::frame_t   recv_msg;
  logic                           cutoff_low_val;
  sound_classifier_pkg::bin_idx_t cutoff_low_msg;
  logic                           cutoff_high_val;
  sound_classifier_pkg::bin_idx_t cutoff_high_msg;
  logic                           threshold_val;
  sound_classifier_pkg::mag_t     threshold_msg;
  logic                           send_val;
  logic                           send_msg;

  integer seed;
  int     cfg_low;   // band and threshold as the DUT currently holds them
  int     cfg_high;
  sound_classifier_pkg::mag_t cfg_thr;
  int     frames_sent;
  int     results_seen;
  int     check_errors;  // scoreboard mismatches
  int     error_count;   // failures seen by the test sequence
  int     tests_passed;
  int     tests_failed;
  int     errors_at_start;

  `include "classifier_model.svh"

  sound_classifier i_sound_classifier (
    .clk             (clk),
    .reset           (reset),
    .recv_val        (recv_val),
    .recv_msg        (recv_msg),
    .cutoff_low_val  (cutoff_low_val),
    .cutoff_low_msg  (cutoff_low_msg),
    .cutoff_high_val (cutoff_high_val),
    .cutoff_high_msg (cutoff_high_msg),
    .threshold_val   (threshold_val),
    .threshold_msg   (threshold_msg),
    .send_val        (send_val),
    .send_msg        (send_msg)
  );

  always #4 clk = ~clk;

  // scoreboard, outputs are settled at the falling edge
  always @(negedge clk) begin
    if (send_val) begin
      if (model_expected.size() == 0) begin
        $display("a result came out at time %0t with no frame pending", $time);
        check_errors++;
      end else begin
        if (send_msg !== model_expected[0]) begin
          $display("[ERROR] %0t frame %0d: send_msg %b, expected %b",
                   $time, results_seen, send_msg, model_expected[0]);
          check_errors++;
        end
        void'(model_expected.pop_front());
      end
      results_seen++;
    end
  end

  function automatic int pick(int lo, int hi);
    return lo + int'(($random(seed) & 32'h7fffffff) % (hi - lo + 1));
  endfunction

  function automatic sound_classifier_pkg::frame_t frame_with_bin(int bin,
                                                                   sound_classifier_pkg::mag_t mag);
    sound_classifier_pkg::frame_t f;

    f = '0;
    f[bin*sound_classifier_pkg::MAG_W +: sound_classifier_pkg::MAG_W] = mag;
    return f;
  endfunction

  function automatic sound_classifier_pkg::frame_t random_frame(sound_classifier_pkg::mag_t limit);
    sound_classifier_pkg::frame_t f;

    for (int i = 0; i < sound_classifier_pkg::N_BINS; i++) begin
      f[i*sound_classifier_pkg::MAG_W +: sound_classifier_pkg::MAG_W] =
        sound_classifier_pkg::mag_t'($random(seed)) & limit;
    end
    return f;
  endfunction

  task automatic send_frame(input sound_classifier_pkg::frame_t frame);
    @(negedge clk);
    recv_val = 1'b1;
    recv_msg = frame;
    model_update(model_detect(frame, cfg_low, cfg_high, cfg_thr));
    frames_sent++;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      recv_val = 1'b0;
    end
  endtask

  // enough silent frames to bring the tracker back to SILENT with no hold
  task automatic send_quiet();
    repeat (int'(sound_classifier_pkg::OFF_FRAMES) + int'(sound_classifier_pkg::HOLD_FRAMES)) begin
      send_frame('0);
    end
  endtask

  task automatic drain();
    int cycles;

    cycles = 0;
    idle(1);
    while (model_expected.size() != 0 && cycles < 20) begin
      idle(1);
      cycles++;
    end
    if (model_expected.size() != 0) begin
      $display("no result for frame %0d after waiting %0d cycles", results_seen, cycles);
      error_count++;
      model_expected.delete();
    end
  endtask

  // only called with no frame in flight
  task automatic write_config(input int low, input int high, input sound_classifier_pkg::mag_t thr);
    @(negedge clk);
    recv_val        = 1'b0;
    cutoff_low_val  = 1'b1;
    cutoff_low_msg  = sound_classifier_pkg::bin_idx_t'(low);
    cutoff_high_val = 1'b1;
    cutoff_high_msg = sound_classifier_pkg::bin_idx_t'(high);
    threshold_val   = 1'b1;
    threshold_msg   = thr;
    @(negedge clk);
    cutoff_low_val  = 1'b0;
    cutoff_high_val = 1'b0;
    threshold_val   = 1'b0;
    cfg_low  = low;
    cfg_high = high;
    cfg_thr  = thr;
  endtask

  task automatic start_test();
    errors_at_start = error_count + check_errors;
  endtask

  task automatic report_test(input string name);
    if (error_count + check_errors == errors_at_start) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, error_count + check_errors - errors_at_start);
      tests_failed++;
    end
  endtask

  initial begin
    int low;
    int high;
    int tmp;
    int bin;
    int burst;
    int latency;
    int sent_before;
    int seen_before;
    bit loud;
    sound_classifier_pkg::mag_t thr;
    sound_classifier_pkg::mag_t limit;

    seed = 32'hfac4e87d;
    clk = 1'b0;
    reset = 1'b1;
    recv_val = 1'b0;
    recv_msg = '0;
    cutoff_low_val = 1'b0;
    cutoff_low_msg = '0;
    cutoff_high_val = 1'b0;
    cutoff_high_msg = '0;
    threshold_val = 1'b0;
    threshold_msg = '0;
    frames_sent = 0;
    results_seen = 0;
    check_errors = 0;
    error_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    cfg_low = 31;  // reset leaves an empty band and a zero threshold
    cfg_high = 0;
    cfg_thr = '0;
    model_reset();

    // 1: reset state and first result latency
    start_test();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    idle(4);  // scoreboard flags any send_val here
    send_frame('0);
    latency = 0;
    do begin
      idle(1);
      latency++;
    end while (!send_val && latency < 10);
    // driven at a falling edge, captured at the next rising edge, result two edges on
    if (!send_val) begin
      $display("no result for the first frame within %0d cycles", latency);
      error_count++;
    end else if (latency != 3) begin
      $display("[ERROR] %0t first result after %0d falling edges, expected 3", $time, latency);
      error_count++;
    end
    drain();
    report_test("reset");

    // 2: band masking
    start_test();
    for (int n = 0; n < 8; n++) begin
      low = pick(0, 31);
      high = pick(0, 31);
      if (low > high) begin
        tmp = low;
        low = high;
        high = tmp;
      end
      write_config(low, high, sound_classifier_pkg::mag_t'(pick(0, 32767)));
      bin = pick(0, 31);
      if (bin < low || bin > high) begin
        repeat (sound_classifier_pkg::ON_FRAMES) send_frame(frame_with_bin(bin, 16'hffff));
      end
      repeat (sound_classifier_pkg::ON_FRAMES) send_frame(frame_with_bin(pick(low, high), 16'hffff));
      send_quiet();
      bin = (pick(0, 1) == 1) ? low : high;  // cutoff bins are inside
      repeat (sound_classifier_pkg::ON_FRAMES) send_frame(frame_with_bin(bin, 16'hffff));
      send_quiet();
      drain();
      low = pick(1, 31);
      write_config(low, pick(0, low - 1), '0);
      repeat (sound_classifier_pkg::ON_FRAMES) send_frame(frame_with_bin(pick(0, 31), 16'hffff));
      send_quiet();
      drain();
    end
    report_test("band masking");

    // 3: threshold compare
    start_test();
    for (int n = 0; n < 8; n++) begin
      thr = sound_classifier_pkg::mag_t'(pick(0, 65534));
      write_config(0, 31, thr);
      bin = pick(0, 31);
      repeat (sound_classifier_pkg::ON_FRAMES) send_frame(frame_with_bin(bin, thr));
      send_quiet();
      repeat (sound_classifier_pkg::ON_FRAMES) send_frame(frame_with_bin(bin, thr + 16'd1));
      send_quiet();
      drain();
    end
    report_test("threshold");

    // 4: onset and release
    start_test();
    write_config(0, 31, 16'h0100);
    send_frame(frame_with_bin(5, 16'h0800));
    send_frame('0);
    repeat (2) send_frame(frame_with_bin(5, 16'h0800));
    send_frame('0);
    repeat (sound_classifier_pkg::ON_FRAMES) send_frame(frame_with_bin(5, 16'h0800));
    repeat (int'(sound_classifier_pkg::OFF_FRAMES) + int'(sound_classifier_pkg::HOLD_FRAMES) + 2) begin
      send_frame('0);
    end
    drain();
    report_test("onset and release");

    // 5: random stream, bursts with gaps and config rewrites between them
    start_test();
    sent_before = frames_sent;
    seen_before = results_seen;
    while (frames_sent - sent_before < 300) begin
      if (pick(0, 3) == 0) begin
        drain();
        low = pick(0, 31);
        high = pick(0, 31);
        if (pick(0, 3) != 0 && low > high) begin
          tmp = low;
          low = high;
          high = tmp;
        end
        write_config(low, high, sound_classifier_pkg::mag_t'(pick(256, 4095)));
      end
      burst = pick(1, 8);
      loud = (pick(0, 1) == 1);
      for (int i = 0; i < burst && frames_sent - sent_before < 300; i++) begin
        limit = (loud != (pick(0, 4) == 0)) ? 16'h0fff : 16'h00ff;
        send_frame(random_frame(limit));
        if (pick(0, 2) == 0) begin
          idle(pick(1, 3));
        end
      end
    end
    drain();
    if (results_seen - seen_before != frames_sent - sent_before) begin
      $display("got %0d results for %0d frames", results_seen - seen_before,
               frames_sent - sent_before);
      error_count++;
    end
    report_test("random stream");

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && error_count + check_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verilog/activity_tracker.sv ====
`timescale 1ns/1ns

module activity_tracker (
  input  logic clk,
  input  logic reset,
  input  logic detect_val,
  input  logic detected,
  output logic send_val,
  output logic send_msg
);

  sound_classifier_pkg::activity_state_t state;
  sound_classifier_pkg::activity_state_t state_next;

  sound_classifier_pkg::frame_count_t on_count;
  sound_classifier_pkg::frame_count_t off_count;
  sound_classifier_pkg::frame_count_t hold_count;

  sound_classifier_pkg::frame_count_t on_next;
  sound_classifier_pkg::frame_count_t off_next;
  sound_classifier_pkg::frame_count_t hold_next;

  logic on_hit;
  logic off_hit;
  logic curr_sound;
  logic msg_next;

  // run counters, a detected frame clears the off run and vice versa
  always_comb begin
    if (detected) begin
      off_next = '0;
      if (on_count == sound_classifier_pkg::ON_FRAMES) begin
        on_next = on_count;  // saturate
      end else begin
        on_next = on_count + sound_classifier_pkg::frame_count_t'(1);
      end
    end else begin
      on_next = '0;
      if (off_count == sound_classifier_pkg::OFF_FRAMES) begin
        off_next = off_count;
      end else begin
        off_next = off_count + sound_classifier_pkg::frame_count_t'(1);
      end
    end
  end

  assign on_hit  = (on_next == sound_classifier_pkg::ON_FRAMES);
  assign off_hit = (off_next == sound_classifier_pkg::OFF_FRAMES);

  // sound this frame, using the state before the update
  assign curr_sound = ((state == sound_classifier_pkg::SOUNDING) || on_hit) && !off_hit;

  // old hold count stretches the flag past the end of sound
  assign msg_next = curr_sound || (hold_count != '0);

  always_comb begin
    state_next = state;
    if (on_hit) begin
      state_next = sound_classifier_pkg::SOUNDING;
    end else if (off_hit) begin
      state_next = sound_classifier_pkg::SILENT;
    end
  end

  always_comb begin
    if (curr_sound) begin
      hold_next = sound_classifier_pkg::HOLD_FRAMES;
    end else if (hold_count != '0) begin
      hold_next = hold_count - sound_classifier_pkg::frame_count_t'(1);
    end else begin
      hold_next = hold_count;
    end
  end

  // everything advances once per frame result
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= sound_classifier_pkg::SILENT;
      on_count   <= '0;
      off_count  <= '0;
      hold_count <= '0;
      send_val   <= 1'b0;
      send_msg   <= 1'b0;
    end else begin
      send_val <= detect_val;
      if (detect_val) begin
        state      <= state_next;
        on_count   <= on_next;
        off_count  <= off_next;
        hold_count <= hold_next;
        send_msg   <= msg_next;
      end
    end
  end

  // runs are exclusive across frames
  assert property (@(posedge clk) disable iff (reset)
    !((on_count != '0) && (off_count != '0)));

  assert property (@(posedge clk) disable iff (reset)
    send_val |-> $past(detect_val));

endmodule

// ==== verilog/band_decode.sv ====
`timescale 1ns/1ns

module band_decode (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            cutoff_low_val,
  input  logic                            cutoff_high_val,
  input  logic                            threshold_val,
  input  sound_classifier_pkg::bin_idx_t  cutoff_low_msg,
  input  sound_classifier_pkg::bin_idx_t  cutoff_high_msg,
  input  sound_classifier_pkg::mag_t      threshold_msg,
  output sound_classifier_pkg::bin_mask_t band_mask,
  output sound_classifier_pkg::mag_t      threshold
);

  sound_classifier_pkg::bin_idx_t  cutoff_low;
  sound_classifier_pkg::bin_idx_t  cutoff_high;
  sound_classifier_pkg::bin_mask_t mask_next;

  // reset leaves an empty band (low above high) so the mask decodes to zero
  always_ff @(posedge clk) begin
    if (reset) begin
      cutoff_low  <= '1;
      cutoff_high <= '0;
      threshold   <= '0;
    end else begin
      if (cutoff_low_val) begin
        cutoff_low <= cutoff_low_msg;
      end
      if (cutoff_high_val) begin
        cutoff_high <= cutoff_high_msg;
      end
      if (threshold_val) begin
        threshold <= threshold_msg;
      end
    end
  end

  // bin i passes when low <= i <= high
  always_comb begin
    for (int i = 0; i < sound_classifier_pkg::N_BINS; i++) begin
      mask_next[i] = (sound_classifier_pkg::bin_idx_t'(i) >= cutoff_low) &&
                     (sound_classifier_pkg::bin_idx_t'(i) <= cutoff_high);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      band_mask <= '0;
    end else begin
      band_mask <= mask_next;  // one cycle behind the cutoff registers
    end
  end

  // empty band after reset holds through the first decode
  assert property (@(posedge clk) reset |=> ##1 (band_mask == '0));

endmodule

// ==== verilog/band_peak.sv ====
`timescale 1ns/1ns

module band_peak (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            recv_val,
  input  sound_classifier_pkg::frame_t    recv_msg,
  input  sound_classifier_pkg::bin_mask_t band_mask,
  input  sound_classifier_pkg::mag_t      threshold,
  output logic                            detect_val,
  output logic                            detected
);

  // captured frame and its one-cycle valid
  sound_classifier_pkg::frame_t frame_q;
  logic                         frame_val;

  // largest in-band magnitude of the captured frame
  sound_classifier_pkg::mag_t peak;

  always_ff @(posedge clk) begin
    if (recv_val) begin
      frame_q <= recv_msg;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_val <= 1'b0;
    end else begin
      frame_val <= recv_val;
    end
  end

  // running maximum over the bins
  // a masked-out bin counts as zero, so an empty band gives a peak of 0
  always_comb begin
    sound_classifier_pkg::mag_t bin_mag;

    peak = '0;
    for (int i = 0; i < sound_classifier_pkg::N_BINS; i++) begin
      if (band_mask[i]) begin
        bin_mag = frame_q[i*sound_classifier_pkg::MAG_W +: sound_classifier_pkg::MAG_W];
      end else begin
        bin_mag = '0;
      end
      if (bin_mag > peak) begin
        peak = bin_mag;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      detect_val <= 1'b0;
      detected   <= 1'b0;
    end else begin
      detect_val <= frame_val;
      if (frame_val) begin
        detected <= (peak > threshold);  // strictly above, equal is not sound
      end
    end
  end

  // every accepted frame yields a compare result two edges later, and only then
  assert property (@(posedge clk) disable iff (reset)
    recv_val |=> ##1 detect_val);

  assert property (@(posedge clk) disable iff (reset)
    detect_val |-> $past(recv_val, 2));

endmodule

// ==== verilog/sound_classifier.sv ====
`timescale 1ns/1ns

module sound_classifier (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           recv_val,
  input  sound_classifier_pkg::frame_t   recv_msg,
  input  logic                           cutoff_low_val,
  input  sound_classifier_pkg::bin_idx_t cutoff_low_msg,
  input  logic                           cutoff_high_val,
  input  sound_classifier_pkg::bin_idx_t cutoff_high_msg,
  input  logic                           threshold_val,
  input  sound_classifier_pkg::mag_t     threshold_msg,
  output logic                           send_val,
  output logic                           send_msg
);

  sound_classifier_pkg::bin_mask_t band_mask;
  sound_classifier_pkg::mag_t      threshold;

  logic detect_val;
  logic detected;

  // decode: band configuration to bin mask
  band_decode i_band_decode (
    .clk             (clk),
    .reset           (reset),
    .cutoff_low_val  (cutoff_low_val),
    .cutoff_high_val (cutoff_high_val),
    .threshold_val   (threshold_val),
    .cutoff_low_msg  (cutoff_low_msg),
    .cutoff_high_msg (cutoff_high_msg),
    .threshold_msg   (threshold_msg),
    .band_mask       (band_mask),
    .threshold       (threshold)
  );

  // execute: capture, band peak, compare
  band_peak i_band_peak (
    .clk        (clk),
    .reset      (reset),
    .recv_val   (recv_val),
    .recv_msg   (recv_msg),
    .band_mask  (band_mask),
    .threshold  (threshold),
    .detect_val (detect_val),
    .detected   (detected)
  );

  // result: onset, release and hold
  activity_tracker i_activity_tracker (
    .clk        (clk),
    .reset      (reset),
    .detect_val (detect_val),
    .detected   (detected),
    .send_val   (send_val),
    .send_msg   (send_msg)
  );

endmodule

// ==== verilog/sound_classifier_pkg.sv ====
package sound_classifier_pkg;

  // frame geometry
  localparam int N_BINS    = 32;
  localparam int MAG_W     = 16;
  localparam int BIN_IDX_W = $clog2(N_BINS);
  localparam int FRAME_W   = N_BINS * MAG_W;

  // width of the per-frame counters, wide enough for every limit below
  localparam int COUNT_W = 4;

  // one magnitude, also used for the detection threshold
  typedef logic [MAG_W-1:0] mag_t;

  // index of one bin, used for the band cutoffs
  typedef logic [BIN_IDX_W-1:0] bin_idx_t;

  // one enable bit per bin
  typedef logic [N_BINS-1:0] bin_mask_t;

  // whole frame, bin i sits in bits i*MAG_W +: MAG_W
  typedef logic [FRAME_W-1:0] frame_t;

  // on, off and hold counters
  typedef logic [COUNT_W-1:0] frame_count_t;

  // detected frames in a row before sound starts
  localparam frame_count_t ON_FRAMES = 4'd3;

  // undetected frames in a row before sound ends
  localparam frame_count_t OFF_FRAMES = 4'd6;

  // frames the output stays up after sound ends
  localparam frame_count_t HOLD_FRAMES = 4'd4;

  typedef enum logic {
    SILENT,
    SOUNDING
  } activity_state_t;

endpackage
